//--- src/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

//////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////

`define ICACHE_ADDR_W   32
`define ICACHE_LINE_W   128
`define ICACHE_NWAY     2
`define ICACHE_NSET     16

// Byte offset inside a 16 byte line
`define ICACHE_OFFSET_W 4
`define ICACHE_INDEX_W  4
`define ICACHE_TAG_W    24

// Victim selection, must stay nonzero
`define ICACHE_LFSR_SEED 16'hace1

`endif

//--- src/icache_mem_pkg.sv
`include "icache_cfg.svh"

package icache_mem_pkg;

    //////////////////////////////////////////////////
    // Address fields
    //////////////////////////////////////////////////

    typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;

    //////////////////////////////////////////////////
    // Storage entries
    //////////////////////////////////////////////////

    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    // One entry of the tag array
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef logic [$clog2(`ICACHE_NWAY)-1:0] way_sel_t;

endpackage

//--- src/icache_ctrl_pkg.sv
package icache_ctrl_pkg;

    // Controller states
    typedef enum logic [2:0] {
        ST_INVALIDATE  = 3'd0,
        ST_IDLE        = 3'd1,
        ST_REFILL_REQ  = 3'd2,
        ST_REFILL_WAIT = 3'd3,
        ST_CACOP_WRITE = 3'd4,
        ST_CACOP_ACK   = 3'd5
    } state_e;

    // Cache operation codes, value 3 acts like hit invalidate
    typedef enum logic [1:0] {
        CACOP_TAG_CLEAR = 2'd0,
        CACOP_INDEX_INV = 2'd1,
        CACOP_HIT_INV   = 2'd2
    } cacop_op_e;

endpackage

//--- src/icache_way_if.sv
`timescale 1ns/1ps

interface icache_way_if;

    // Controller side
    logic                       en;
    logic                       we;
    icache_mem_pkg::index_t     index;
    icache_mem_pkg::tag_t       cmp_tag;
    icache_mem_pkg::tag_entry_t wentry;
    icache_mem_pkg::line_t      wline;

    // Lookup result, one cycle after en
    logic                  hit;
    icache_mem_pkg::line_t rline;

    modport ctrl (
        output en, we, index, cmp_tag, wentry, wline
    );

    modport way (
        input  en, we, index, cmp_tag, wentry, wline,
        output hit, rline
    );

    modport sel (
        input hit, rline
    );

endinterface

//--- src/icache_way.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_way (
    input logic       clk,
    icache_way_if.way port
);

    //////////////////////////////////////////////////
    // Arrays
    //////////////////////////////////////////////////

    icache_mem_pkg::tag_entry_t tag_mem  [`ICACHE_NSET];
    icache_mem_pkg::line_t      data_mem [`ICACHE_NSET];

    // Synchronous read registers
    icache_mem_pkg::tag_entry_t tag_q;
    icache_mem_pkg::line_t      line_q;

    // Single port, a write blocks the read
    always_ff @(posedge clk) begin
        if (port.we) begin
            tag_mem[port.index] <= port.wentry;
            // Invalidation only touches the tag
            if (port.wentry.valid) begin
                data_mem[port.index] <= port.wline;
            end
        end else if (port.en) begin
            tag_q  <= tag_mem[port.index];
            line_q <= data_mem[port.index];
        end
    end

    //////////////////////////////////////////////////
    // Tag compare
    //////////////////////////////////////////////////

    assign port.hit   = tag_q.valid && (tag_q.tag == port.cmp_tag);
    assign port.rline = line_q;

endmodule

//--- src/icache_way_sel.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_way_sel (
    icache_way_if.sel             ways [`ICACHE_NWAY],
    input  logic                  refill_done_i,
    input  icache_mem_pkg::line_t mem_rdata_i,
    output logic                  lookup_hit_o,
    output icache_mem_pkg::line_t rdata_o
);

    localparam int NWAY = `ICACHE_NWAY;

    logic [NWAY-1:0]       hit_vec;
    icache_mem_pkg::line_t line_arr [NWAY];
    icache_mem_pkg::line_t hit_line;

    for (genvar g = 0; g < NWAY; g++) begin : g_collect
        assign hit_vec[g]  = ways[g].hit;
        assign line_arr[g] = ways[g].rline;
    end

    // At most one way hits, so an AND-OR mux is enough
    always_comb begin
        hit_line = '0;
        for (int i = 0; i < NWAY; i++) begin
            if (hit_vec[i]) hit_line = hit_line | line_arr[i];
        end
    end

    assign lookup_hit_o = |hit_vec;

    // Refill data bypasses the arrays
    assign rdata_o = refill_done_i ? mem_rdata_i : hit_line;

endmodule

//--- src/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_i,
    input  logic                       uncached_i,
    input  icache_mem_pkg::addr_t      addr_i,
    output logic                       ack_o,
    output logic                       rvalid_o,
    output logic                       refill_done_o,
    input  logic                       invalid_i,
    input  logic                       cacop_i,
    input  icache_ctrl_pkg::cacop_op_e cacop_mode_i,
    input  icache_mem_pkg::addr_t      cacop_addr_i,
    output logic                       cacop_ack_o,
    output logic                       mem_req_o,
    output icache_mem_pkg::addr_t      mem_addr_o,
    input  logic                       mem_ready_i,
    input  logic                       mem_rvalid_i,
    input  icache_mem_pkg::line_t      mem_rdata_i,
    input  logic                       lookup_hit_i,
    icache_way_if.ctrl                 ways [`ICACHE_NWAY]
);

    localparam int NWAY = `ICACHE_NWAY;
    localparam int OFF  = `ICACHE_OFFSET_W;
    localparam int IDXW = `ICACHE_INDEX_W;

    icache_ctrl_pkg::state_e state, next_state;

    // Request stage
    logic                  stage_valid;
    logic                  stage_unc;
    icache_mem_pkg::addr_t stage_addr;

    icache_mem_pkg::index_t     inv_cnt;
    logic [15:0]                lfsr;
    icache_mem_pkg::way_sel_t   victim;
    icache_mem_pkg::way_sel_t   cacop_way;
    logic                       cacop_all;
    logic                       accept;
    logic                       miss_now;
    logic                       req_phase;
    logic                       fill;
    logic [NWAY-1:0]            way_en;
    logic [NWAY-1:0]            way_we;
    icache_mem_pkg::index_t     way_index;
    icache_mem_pkg::tag_entry_t wentry;

    //////////////////////////////////////////////////
    // Handshake and refill strobes
    //////////////////////////////////////////////////

    assign ack_o = (state == icache_ctrl_pkg::ST_IDLE) && !invalid_i && !cacop_i &&
                   (!stage_valid || (!stage_unc && lookup_hit_i));
    assign accept = req_i && ack_o;

    assign miss_now = (state == icache_ctrl_pkg::ST_IDLE) && stage_valid &&
                      (stage_unc || !lookup_hit_i);
    assign req_phase = miss_now || (state == icache_ctrl_pkg::ST_REFILL_REQ);
    // Line may come back in the same cycle as ready
    assign fill = mem_rvalid_i &&
                  ((state == icache_ctrl_pkg::ST_REFILL_WAIT) || (req_phase && mem_ready_i));

    assign mem_req_o     = req_phase;
    assign mem_addr_o    = {stage_addr[`ICACHE_ADDR_W-1:OFF], {OFF{1'b0}}};
    assign refill_done_o = fill;
    assign rvalid_o      = fill || ((state == icache_ctrl_pkg::ST_IDLE) && stage_valid &&
                                    !stage_unc && lookup_hit_i);
    assign cacop_ack_o   = (state == icache_ctrl_pkg::ST_CACOP_ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (accept) begin
            stage_valid <= 1'b1;
        end else if (rvalid_o) begin
            stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_unc  <= uncached_i;
            stage_addr <= addr_i;
        end
    end

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) state <= icache_ctrl_pkg::ST_INVALIDATE;
        else state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            icache_ctrl_pkg::ST_INVALIDATE: begin
                if (inv_cnt == icache_mem_pkg::index_t'(`ICACHE_NSET - 1))
                    next_state = icache_ctrl_pkg::ST_IDLE;
            end
            icache_ctrl_pkg::ST_IDLE: begin
                if (miss_now) begin
                    if (fill) next_state = icache_ctrl_pkg::ST_IDLE;
                    else if (mem_ready_i) next_state = icache_ctrl_pkg::ST_REFILL_WAIT;
                    else next_state = icache_ctrl_pkg::ST_REFILL_REQ;
                end else if (invalid_i) begin
                    next_state = icache_ctrl_pkg::ST_INVALIDATE;
                end else if (cacop_i) begin
                    next_state = icache_ctrl_pkg::ST_CACOP_WRITE;
                end
            end
            icache_ctrl_pkg::ST_REFILL_REQ: begin
                if (fill) next_state = icache_ctrl_pkg::ST_IDLE;
                else if (mem_ready_i) next_state = icache_ctrl_pkg::ST_REFILL_WAIT;
            end
            icache_ctrl_pkg::ST_REFILL_WAIT: begin
                if (fill) next_state = icache_ctrl_pkg::ST_IDLE;
            end
            icache_ctrl_pkg::ST_CACOP_WRITE: next_state = icache_ctrl_pkg::ST_CACOP_ACK;
            default: next_state = icache_ctrl_pkg::ST_IDLE;
        endcase
    end

    // Wraps back to zero at the end of the walk
    always_ff @(posedge clk) begin
        if (rst) inv_cnt <= '0;
        else if (state == icache_ctrl_pkg::ST_INVALIDATE) inv_cnt <= inv_cnt + 1'b1;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge clk) begin
        if (rst) lfsr <= `ICACHE_LFSR_SEED;
        else lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    end
    assign victim = icache_mem_pkg::way_sel_t'(lfsr[0]);

    //////////////////////////////////////////////////
    // Way control
    //////////////////////////////////////////////////

    assign cacop_way = icache_mem_pkg::way_sel_t'(cacop_addr_i[0]);

    always_comb begin
        case (cacop_mode_i)
            icache_ctrl_pkg::CACOP_TAG_CLEAR,
            icache_ctrl_pkg::CACOP_INDEX_INV: cacop_all = 1'b0;
            default: cacop_all = 1'b1;
        endcase
    end

    always_comb begin
        way_index = addr_i[OFF +: IDXW];
        way_en    = '0;
        way_we    = '0;
        wentry    = '0;
        case (state)
            icache_ctrl_pkg::ST_INVALIDATE: begin
                way_index = inv_cnt;
                way_we    = '1;
            end
            icache_ctrl_pkg::ST_CACOP_WRITE: begin
                way_index = cacop_addr_i[OFF +: IDXW];
                for (int i = 0; i < NWAY; i++) begin
                    if (cacop_all || cacop_way == icache_mem_pkg::way_sel_t'(i))
                        way_we[i] = 1'b1;
                end
            end
            default: begin
                if (fill) begin
                    way_index    = stage_addr[OFF +: IDXW];
                    wentry.valid = 1'b1;
                    wentry.tag   = stage_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
                    // Uncached lines are returned but never allocated
                    if (!stage_unc) way_we[victim] = 1'b1;
                end else begin
                    way_en = {NWAY{accept && !uncached_i}};
                end
            end
        endcase
    end

    for (genvar g = 0; g < NWAY; g++) begin : g_way_ctl
        assign ways[g].en      = way_en[g];
        assign ways[g].we      = way_we[g];
        assign ways[g].index   = way_index;
        assign ways[g].cmp_tag = stage_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        assign ways[g].wentry  = wentry;
        assign ways[g].wline   = mem_rdata_i;
    end

endmodule

//--- src/icache_top.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_top (
    input  logic                       clk,
    input  logic                       rst,

    // Read port
    input  logic                       req_i,
    input  logic                       uncached_i,
    input  icache_mem_pkg::addr_t      addr_i,
    output logic                       ack_o,
    output logic                       rvalid_o,
    output icache_mem_pkg::line_t      rdata_o,

    // Maintenance
    input  logic                       invalid_i,
    input  logic                       cacop_i,
    input  icache_ctrl_pkg::cacop_op_e cacop_mode_i,
    input  icache_mem_pkg::addr_t      cacop_addr_i,
    output logic                       cacop_ack_o,

    // Memory port
    output logic                       mem_req_o,
    output icache_mem_pkg::addr_t      mem_addr_o,
    input  logic                       mem_ready_i,
    input  logic                       mem_rvalid_i,
    input  icache_mem_pkg::line_t      mem_rdata_i
);

    logic lookup_hit;
    logic refill_done;

    icache_way_if way_bus [`ICACHE_NWAY] ();

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .uncached_i    (uncached_i),
        .addr_i        (addr_i),
        .ack_o         (ack_o),
        .rvalid_o      (rvalid_o),
        .refill_done_o (refill_done),
        .invalid_i     (invalid_i),
        .cacop_i       (cacop_i),
        .cacop_mode_i  (cacop_mode_i),
        .cacop_addr_i  (cacop_addr_i),
        .cacop_ack_o   (cacop_ack_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_ready_i   (mem_ready_i),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rdata_i   (mem_rdata_i),
        .lookup_hit_i  (lookup_hit),
        .ways          (way_bus)
    );

    //////////////////////////////////////////////////
    // Ways
    //////////////////////////////////////////////////

    for (genvar g = 0; g < `ICACHE_NWAY; g++) begin : g_way
        icache_way u_way (
            .clk  (clk),
            .port (way_bus[g])
        );
    end

    icache_way_sel u_way_sel (
        .ways          (way_bus),
        .refill_done_i (refill_done),
        .mem_rdata_i   (mem_rdata_i),
        .lookup_hit_o  (lookup_hit),
        .rdata_o       (rdata_o)
    );

endmodule

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset held for two rising edges
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

//--- testbench/icache_sva.sv
`timescale 1ns/1ps

module icache_sva (
    input logic clk,
    input logic rst,
    input logic req_i,
    input logic ack_o,
    input logic rvalid_o,
    input logic mem_req_o,
    input logic mem_ready_i,
    input logic cacop_ack_o
);

    // Requests accepted but not yet returned
    int outstanding;

    // Failed assertions so far
    int fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(req_i && ack_o) - int'(rvalid_o);
        end
    end

    a_rvalid_owned: assert property (@(posedge clk) disable iff (rst)
        rvalid_o |-> outstanding != 0)
        else begin
            $error("rvalid_o without an outstanding request");
            fail_cnt++;
        end

    a_mem_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_o && !mem_ready_i |=> mem_req_o)
        else begin
            $error("mem_req_o dropped before mem_ready_i");
            fail_cnt++;
        end

    a_cacop_pulse: assert property (@(posedge clk) disable iff (rst)
        cacop_ack_o |=> !cacop_ack_o)
        else begin
            $error("cacop_ack_o longer than one cycle");
            fail_cnt++;
        end

    a_no_ack_in_miss: assert property (@(posedge clk) disable iff (rst)
        mem_req_o |-> !ack_o)
        else begin
            $error("ack_o high during a memory request");
            fail_cnt++;
        end

endmodule

bind icache_top icache_sva u_sva (.*);

//--- testbench/icache_tb.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_tb;

    localparam int NLINE = 48;

    logic clk;
    logic rst;
    logic req_i;
    logic uncached_i;
    icache_mem_pkg::addr_t addr_i;
    logic ack_o;
    logic rvalid_o;
    icache_mem_pkg::line_t rdata_o;
    logic invalid_i;
    logic cacop_i;
    icache_ctrl_pkg::cacop_op_e cacop_mode_i;
    icache_mem_pkg::addr_t cacop_addr_i;
    logic cacop_ack_o;
    logic mem_req_o;
    icache_mem_pkg::addr_t mem_addr_o;
    logic mem_ready_i;
    logic mem_rvalid_i;
    icache_mem_pkg::line_t mem_rdata_i;

    // Reference model with one flag per test line
    bit may_cached [NLINE];

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_o(rst));

    icache_top u_icache_top (.*);

    function automatic icache_mem_pkg::addr_t line_addr(input int k);
        logic [`ICACHE_TAG_W-1:0] tag;
        tag = 24'h0001a0 + k / 16;
        return {tag, 4'(k % 16), 4'h0};
    endfunction

    function automatic icache_mem_pkg::line_t mem_pattern(input icache_mem_pkg::addr_t a);
        return {a ^ 32'h5a5a_0000, ~a, a * 32'h9e37_79b9, {a[15:0], a[31:16]}};
    endfunction

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // Bound port checker
    always @(negedge clk) begin
        assert (u_icache_top.u_sva.fail_cnt == 0)
        else fail_stop("a concurrent assertion on the cache ports failed");
    end

    //////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////

    initial begin
        int st;
        int cnt;
        icache_mem_pkg::addr_t maddr;
        st = 0;
        cnt = 0;
        maddr = '0;
        forever begin
            @(negedge clk);
            mem_ready_i = 1'b0;
            mem_rvalid_i = 1'b0;
            if (st == 0 && mem_req_o) begin
                cnt = $urandom % 6;
                st = 1;
            end
            if (st == 1) begin
                if (cnt == 0) begin
                    mem_ready_i = 1'b1;
                    maddr = mem_addr_o;
                    cnt = $urandom % 6;
                    if (cnt == 0) begin
                        mem_rvalid_i = 1'b1;
                        mem_rdata_i = mem_pattern(maddr);
                        st = 0;
                    end else begin
                        st = 2;
                    end
                end else begin
                    cnt--;
                end
            end else if (st == 2) begin
                if (cnt <= 1) begin
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i = mem_pattern(maddr);
                    st = 0;
                end else begin
                    cnt--;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////

    // With no request pending, ack_o high means the FSM is in IDLE
    task automatic wait_idle();
        int cnt;
        cnt = 0;
        @(negedge clk);
        #1;
        while (ack_o !== 1'b1) begin
            cnt++;
            if (cnt > 32) fail_stop("timeout: cache never returned to idle");
            @(negedge clk);
            #1;
        end
    endtask

    task automatic read_line(input int k, input logic unc, input bit must_hit);
        icache_mem_pkg::addr_t a;
        int wait_cnt;
        int lat;
        bit saw_mem;
        bit must_miss;
        bit done;
        a = line_addr(k) | ($urandom % 16);
        must_miss = unc || !may_cached[k];
        @(negedge clk);
        req_i = 1'b1;
        uncached_i = unc;
        addr_i = a;
        #1;
        wait_cnt = 0;
        while (!ack_o) begin
            wait_cnt++;
            if (wait_cnt > 64) fail_stop("timeout: read request was never accepted");
            @(negedge clk);
            #1;
        end
        lat = 0;
        saw_mem = 0;
        done = 0;
        while (!done) begin
            @(negedge clk);
            req_i = 1'b0;
            uncached_i = 1'b0;
            addr_i = '0;
            #1;
            lat++;
            if (mem_req_o) begin
                saw_mem = 1;
                assert (mem_addr_o == line_addr(k))
                else fail_stop($sformatf("mismatch at %0t: mem_addr_o %h, expected %h",
                                         $time, mem_addr_o, line_addr(k)));
            end
            if (rvalid_o) begin
                done = 1;
                assert (rdata_o == mem_pattern(line_addr(k)))
                else fail_stop($sformatf("mismatch at %0t: rdata_o %h for address %h",
                                         $time, rdata_o, a));
            end else if (lat > 64) begin
                fail_stop("timeout: read data never returned");
            end
        end
        assert (!must_miss || saw_mem)
        else fail_stop($sformatf("mismatch at %0t: read of %h hit, miss expected", $time, a));
        assert (!must_hit || (!saw_mem && lat == 1))
        else fail_stop($sformatf("mismatch at %0t: read of %h missed, hit expected", $time, a));
        assert (saw_mem || lat == 1)
        else fail_stop($sformatf("mismatch at %0t: hit latency %0d", $time, lat));
        if (!unc) may_cached[k] = 1;
    endtask

    task automatic invalidate_all();
        @(negedge clk);
        invalid_i = 1'b1;
        @(negedge clk);
        invalid_i = 1'b0;
        for (int i = 0; i < NLINE; i++) may_cached[i] = 0;
        wait_idle();
    endtask

    task automatic run_cacop(input int idx, input int way, input int mode);
        int cnt;
        @(negedge clk);
        cacop_i = 1'b1;
        cacop_mode_i = icache_ctrl_pkg::cacop_op_e'(mode);
        cacop_addr_i = {24'h0, 4'(idx), 3'b000, 1'(way)};
        #1;
        cnt = 0;
        while (!cacop_ack_o) begin
            cnt++;
            if (cnt > 8) fail_stop("timeout: cacop was never acknowledged");
            @(negedge clk);
            #1;
        end
        assert (cnt == 2)
        else fail_stop($sformatf("mismatch at %0t: cacop ack after %0d cycles", $time, cnt));
        @(negedge clk);
        cacop_i = 1'b0;
        // Single way clears leave the flag set since it only means may be cached
        if (mode >= 2) begin
            for (int i = 0; i < NLINE; i++) begin
                if (i % 16 == idx) may_cached[i] = 0;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        int r;
        int k;
        bit was_cached;
        void'($urandom(32'hac69_7ae5));
        req_i = 1'b0;
        uncached_i = 1'b0;
        addr_i = '0;
        invalid_i = 1'b0;
        cacop_i = 1'b0;
        cacop_mode_i = icache_ctrl_pkg::CACOP_TAG_CLEAR;
        cacop_addr_i = '0;
        mem_ready_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i = '0;
        for (int i = 0; i < NLINE; i++) may_cached[i] = 0;
        // Reset walk of all sets
        wait_idle();
        for (int n = 0; n < 400; n++) begin
            r = $urandom % 100;
            k = $urandom % NLINE;
            if (r < 65) begin
                was_cached = may_cached[k];
                read_line(k, 1'b0, 1'b0);
                // Repeat straight after a refill
                if (!was_cached && ($urandom % 2)) read_line(k, 1'b0, 1'b1);
            end else if (r < 80) begin
                read_line(k, 1'b1, 1'b0);
            end else if (r < 86) begin
                invalidate_all();
            end else begin
                run_cacop(k % 16, $urandom % 2, $urandom % 4);
            end
        end
        if (u_icache_top.u_sva.fail_cnt == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_stop("a concurrent assertion on the cache ports failed");
        end
    end

endmodule

//--- all.f
+incdir+src
src/icache_mem_pkg.sv
src/icache_ctrl_pkg.sv
src/icache_way_if.sv
src/icache_way.sv
src/icache_way_sel.sv
src/icache_ctrl.sv
src/icache_top.sv
testbench/tb_clk_gen.sv
testbench/icache_sva.sv
testbench/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - src
    files:
      - src/icache_mem_pkg.sv
      - src/icache_ctrl_pkg.sv
      - src/icache_way_if.sv
      - src/icache_way.sv
      - src/icache_way_sel.sv
      - src/icache_ctrl.sv
      - src/icache_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_clk_gen.sv
      - testbench/icache_sva.sv
      - testbench/icache_tb.sv
